/* Bender.yml */
package:
  name: inst_split

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/split_pkg.sv
      - hw/split_seq_ctrl.sv
      - hw/lsd_uop_gen.sv
      - hw/amo_uop_gen.sv
      - hw/fnc_uop_gen.sv
      - hw/inst_split_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_inst_split.sv

/* build.f */
+incdir+hw
hw/split_pkg.sv
hw/split_seq_ctrl.sv
hw/lsd_uop_gen.sv
hw/amo_uop_gen.sv
hw/fnc_uop_gen.sv
hw/inst_split_top.sv
testbench/tb_inst_split.sv

/* hw/amo_uop_gen.sv */
`timescale 1ns/1ps
// Builds fence, lr, sc and AMO micro-ops
// Fences are full iorw fences on CP0, ordering comes from slot only
`include "split_settings.svh"

module amo_uop_gen (
  input  split_pkg::inst_t     in_inst,
  input  split_pkg::uop_slot_e slot,
  output split_pkg::uop_t      amo_uop
);
  import split_pkg::*;

  logic [4:0] funct5;
  logic       is_word;
  logic       is_lr;
  logic       is_sc;
  reg_idx_t   rs1_f;
  reg_idx_t   rs2_f;
  reg_idx_t   rd_f;

  assign funct5  = in_inst[31:27];
  // funct3 010 word, 011 double
  assign is_word = !in_inst[12];
  assign is_lr   = (funct5 == `SPLIT_AMO_LR);
  assign is_sc   = (funct5 == `SPLIT_AMO_SC);
  assign rs1_f   = in_inst[19:15];
  assign rs2_f   = in_inst[24:20];
  assign rd_f    = in_inst[11:7];

  always_comb
  begin
    amo_uop = '0;
    case (slot)
      // --------------------
      // Fence around the body
      // --------------------
      SLOT_FENCE_PRE, SLOT_FENCE_POST:
      begin
        amo_uop.eu   = EU_CP0;
        amo_uop.func = `SPLIT_FUNC_FENCE;
      end
      // --------------------
      // Memory body
      // --------------------
      default:
      begin
        amo_uop.eu       = EU_LSU;
        amo_uop.src0_vld = 1'b1;
        amo_uop.src0_reg = rs1_f;
        amo_uop.dst_vld  = 1'b1;
        amo_uop.dst_reg  = rd_f;
        if (is_lr)
        begin
          amo_uop.func = is_word ? `SPLIT_FUNC_LR_W : `SPLIT_FUNC_LR_D;
        end
        else if (is_sc)
        begin
          amo_uop.func     = is_word ? `SPLIT_FUNC_SC_W : `SPLIT_FUNC_SC_D;
          amo_uop.src2_vld = 1'b1;
          amo_uop.src2_reg = rs2_f;
        end
        else
        begin
          amo_uop.func     = is_word ? `SPLIT_FUNC_AMO_W : `SPLIT_FUNC_AMO_D;
          amo_uop.src2_vld = 1'b1;
          amo_uop.src2_reg = rs2_f;
          // ALU operation travels as funct5
          amo_uop.imm_vld  = 1'b1;
          amo_uop.imm      = imm_t'(funct5);
        end
      end
    endcase
  end

endmodule

/* hw/fnc_uop_gen.sv */
`timescale 1ns/1ps
// Builds the sfence and sync pair for sfence.vma
`include "split_settings.svh"

module fnc_uop_gen (
  input  split_pkg::inst_t     in_inst,
  input  split_pkg::uop_slot_e slot,
  output split_pkg::uop_t      fnc_uop
);
  import split_pkg::*;

  reg_idx_t rs1_f;
  reg_idx_t rs2_f;

  // Address in rs1, ASID in rs2
  assign rs1_f = in_inst[19:15];
  assign rs2_f = in_inst[24:20];

  always_comb
  begin
    fnc_uop          = '0;
    fnc_uop.eu       = EU_CP0;
    fnc_uop.src0_vld = 1'b1;
    fnc_uop.src0_reg = rs1_f;
    if (slot == SLOT_MAIN)
    begin
      // TLB invalidate
      fnc_uop.func     = `SPLIT_FUNC_SFENCE;
      fnc_uop.src1_vld = 1'b1;
      fnc_uop.src1_reg = rs2_f;
    end
    else
    begin
      // Pipeline sync after the invalidate
      fnc_uop.func = `SPLIT_FUNC_SYNCI;
    end
  end

endmodule

/* hw/inst_split_top.sv */
`timescale 1ns/1ps
// Splitter top, valid/ready on both sides
// split_clk is free-running, flush restarts the current instruction

module inst_split_top (
  input  logic             split_clk,
  input  logic             cpurst_b,
  input  logic             in_valid,
  input  split_pkg::inst_t in_inst,
  input  logic             custom_en,
  input  logic             flush,
  input  logic             out_ready,
  output logic             in_ready,
  output logic             out_valid,
  output split_pkg::uop_t  out_uop
);
  import split_pkg::*;

  uop_slot_e slot;
  uop_t      lsd_uop;
  uop_t      amo_uop;
  uop_t      fnc_uop;

  // Sequencer and output mux
  split_seq_ctrl u_split_seq_ctrl (
    .split_clk (split_clk),
    .cpurst_b  (cpurst_b),
    .in_valid  (in_valid),
    .in_inst   (in_inst),
    .custom_en (custom_en),
    .flush     (flush),
    .out_ready (out_ready),
    .lsd_uop   (lsd_uop),
    .amo_uop   (amo_uop),
    .fnc_uop   (fnc_uop),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_uop   (out_uop),
    .slot      (slot)
  );

  // Per-class builders, all driven by the same slot
  lsd_uop_gen u_lsd_uop_gen (
    .in_inst (in_inst),
    .slot    (slot),
    .lsd_uop (lsd_uop)
  );

  amo_uop_gen u_amo_uop_gen (
    .in_inst (in_inst),
    .slot    (slot),
    .amo_uop (amo_uop)
  );

  fnc_uop_gen u_fnc_uop_gen (
    .in_inst (in_inst),
    .slot    (slot),
    .fnc_uop (fnc_uop)
  );

endmodule

/* hw/lsd_uop_gen.sv */
`timescale 1ns/1ps
// Builds both halves of a paired load/store
// Offsets are zero-extended, second half targets the rs2-field register
`include "split_settings.svh"

module lsd_uop_gen (
  input  split_pkg::inst_t     in_inst,
  input  split_pkg::uop_slot_e slot,
  output split_pkg::uop_t      lsd_uop
);
  import split_pkg::*;

  logic       is_load;
  logic       is_word;
  logic       second;
  logic [5:0] off_first;
  logic [5:0] off_sel;
  reg_idx_t   data_reg;

  // funct3 bit 0 set for stores
  assign is_load = !in_inst[12];
  // funct5 bit 0 set for double forms
  assign is_word = !in_inst[27];
  assign second  = (slot == SLOT_SECOND);

  // imm2 scaled by the pair size
  assign off_first = is_word ? {1'b0, in_inst[26:25], 3'b000}
                             : {in_inst[26:25], 4'b0000};
  // Second access is one element further
  assign off_sel   = second ? off_first + (is_word ? 6'd4 : 6'd8) : off_first;
  assign data_reg  = second ? in_inst[24:20] : in_inst[11:7];

  always_comb
  begin
    lsd_uop          = '0;
    lsd_uop.eu       = EU_LSU;
    // Base from rs1 on both halves
    lsd_uop.src0_vld = 1'b1;
    lsd_uop.src0_reg = in_inst[19:15];
    lsd_uop.imm_vld  = 1'b1;
    lsd_uop.imm      = imm_t'(off_sel);
    if (is_load)
    begin
      // funct5 bit 1 picks the unsigned word load
      if (!is_word)
        lsd_uop.func = `SPLIT_FUNC_LD;
      else if (in_inst[28])
        lsd_uop.func = `SPLIT_FUNC_LWU;
      else
        lsd_uop.func = `SPLIT_FUNC_LW;
      lsd_uop.dst_vld = 1'b1;
      lsd_uop.dst_reg = data_reg;
    end
    else
    begin
      // Store data comes from the same fields
      lsd_uop.func     = is_word ? `SPLIT_FUNC_SW : `SPLIT_FUNC_SD;
      lsd_uop.src2_vld = 1'b1;
      lsd_uop.src2_reg = data_reg;
    end
  end

endmodule

/* hw/split_pkg.sv */
// Types shared by the splitter blocks and the testbench
// Register indices are 5 bits, no extended register file
`include "split_settings.svh"

package split_pkg;

  // Raw fetched instruction
  typedef logic [`SPLIT_INST_W-1:0] inst_t;
  // Architectural register index
  typedef logic [4:0]               reg_idx_t;
  // Immediate operand, always 64 bits on the micro-op
  typedef logic [`SPLIT_IMM_W-1:0]  imm_t;
  // Micro-op function code
  typedef logic [`SPLIT_FUNC_W-1:0] func_t;

  // Target execution unit
  typedef enum logic [1:0] {
    EU_NONE = 2'd0,
    EU_LSU  = 2'd1,
    EU_CP0  = 2'd2
  } exec_unit_e;

  // Decoded split class
  typedef enum logic [1:0] {
    CLS_NONE = 2'd0,
    CLS_LSD  = 2'd1,
    CLS_AMO  = 2'd2,
    CLS_FNC  = 2'd3
  } split_class_e;

  // Position of a micro-op inside its sequence
  typedef enum logic [1:0] {
    SLOT_FENCE_PRE  = 2'd0,
    SLOT_MAIN       = 2'd1,
    SLOT_SECOND     = 2'd2,
    SLOT_FENCE_POST = 2'd3
  } uop_slot_e;

  // One micro-op as seen by the issue stage
  typedef struct packed {
    exec_unit_e eu;
    func_t      func;
    logic       src0_vld;
    reg_idx_t   src0_reg;
    logic       src1_vld;
    reg_idx_t   src1_reg;
    logic       src2_vld;
    reg_idx_t   src2_reg;
    logic       imm_vld;
    imm_t       imm;
    logic       dst_vld;
    reg_idx_t   dst_reg;
    logic       split;
    inst_t      opcode;
  } uop_t;

endpackage

/* hw/split_seq_ctrl.sv */
`timescale 1ns/1ps
// Class decode and step sequencer for one instruction in flight
// Output is combinational on in_valid, in_inst and the step register
// Paired load/store only decodes while custom_en is high
`include "split_settings.svh"

module split_seq_ctrl (
  input  logic                 split_clk,
  input  logic                 cpurst_b,
  input  logic                 in_valid,
  input  split_pkg::inst_t     in_inst,
  input  logic                 custom_en,
  input  logic                 flush,
  input  logic                 out_ready,
  input  split_pkg::uop_t      lsd_uop,
  input  split_pkg::uop_t      amo_uop,
  input  split_pkg::uop_t      fnc_uop,
  output logic                 in_ready,
  output logic                 out_valid,
  output split_pkg::uop_t      out_uop,
  output split_pkg::uop_slot_e slot
);
  import split_pkg::*;

  logic [6:0]   opc;
  logic [2:0]   funct3;
  logic [4:0]   funct5;
  logic [6:0]   funct7;
  reg_idx_t     rs2_f;
  reg_idx_t     rd_f;
  logic         aq;
  logic         rl;
  logic         lsd_hit;
  logic         amo_hit;
  logic         fnc_hit;
  split_class_e cls;
  logic [1:0]   seq_len;
  logic [1:0]   step_q;
  logic [1:0]   amo_idx;
  logic         last;
  logic         fire;

  // --------------------
  // Class decode
  // --------------------
  assign opc    = in_inst[6:0];
  assign funct3 = in_inst[14:12];
  assign funct5 = in_inst[31:27];
  assign funct7 = in_inst[31:25];
  assign rs2_f  = in_inst[24:20];
  assign rd_f   = in_inst[11:7];
  // Ordering bits of the atomics
  assign aq     = in_inst[26];
  assign rl     = in_inst[25];

  // Vendor paired forms
  assign lsd_hit = custom_en && (opc == `SPLIT_OPC_CUSTOM0)
                   && ({funct5, funct3} inside {`SPLIT_LSD_LWD, `SPLIT_LSD_LWUD,
                                                `SPLIT_LSD_LDD, `SPLIT_LSD_SWD,
                                                `SPLIT_LSD_SDD});

  // Word or double forms only
  // lr needs rs2 zero
  // funct5[1:0] == 0 covers add, xor, or, and, min, max, minu, maxu
  assign amo_hit = (opc == `SPLIT_OPC_AMO) && (funct3[2:1] == 2'b01)
                   && (((funct5 == `SPLIT_AMO_LR) && (rs2_f == 5'd0))
                       || (funct5 == `SPLIT_AMO_SC)
                       || (funct5 == `SPLIT_AMO_SWAP)
                       || (funct5[1:0] == 2'b00));

  // sfence.vma with rd and funct3 zero
  assign fnc_hit = (opc == `SPLIT_OPC_SYSTEM) && (funct7 == `SPLIT_SFENCE_F7)
                   && (funct3 == 3'b000) && (rd_f == 5'd0);

  always_comb
  begin
    if (lsd_hit)
      cls = CLS_LSD;
    else if (amo_hit)
      cls = CLS_AMO;
    else if (fnc_hit)
      cls = CLS_FNC;
    else
      cls = CLS_NONE;
  end

  // --------------------
  // Sequence length and slot
  // --------------------
  always_comb
  begin
    case (cls)
      CLS_LSD, CLS_FNC: seq_len = 2'd2;
      // Body plus optional fences
      CLS_AMO: seq_len = 2'd1 + {1'b0, rl} + {1'b0, aq};
      default: seq_len = 2'd1;
    endcase
  end

  // Skip the leading fence when rl is clear
  assign amo_idx = step_q + {1'b0, ~rl};

  always_comb
  begin
    case (cls)
      CLS_AMO:
      begin
        case (amo_idx)
          2'd0:    slot = SLOT_FENCE_PRE;
          2'd1:    slot = SLOT_MAIN;
          default: slot = SLOT_FENCE_POST;
        endcase
      end
      CLS_LSD, CLS_FNC: slot = (step_q == 2'd0) ? SLOT_MAIN : SLOT_SECOND;
      default: slot = SLOT_MAIN;
    endcase
  end

  // --------------------
  // Handshake and step
  // --------------------
  assign last      = (step_q == seq_len - 2'd1);
  // Nothing leaves during a flush cycle
  assign out_valid = in_valid && (cls != CLS_NONE) && !flush;
  assign fire      = out_valid && out_ready;
  // Non-split instructions drop straight through
  assign in_ready  = in_valid && !flush && ((cls == CLS_NONE) || (out_ready && last));

  always_ff @(posedge split_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      step_q <= 2'd0;
    else if (flush)
      step_q <= 2'd0;
    else if (fire)
    begin
      if (last)
        step_q <= 2'd0;
      else
        step_q <= step_q + 2'd1;
    end
  end

  // Pick the generator, then finish split and opcode
  always_comb
  begin
    case (cls)
      CLS_LSD: out_uop = lsd_uop;
      CLS_AMO: out_uop = amo_uop;
      CLS_FNC: out_uop = fnc_uop;
      default: out_uop = '0;
    endcase
    out_uop.split  = !last;
    out_uop.opcode = in_inst;
  end

  // --------------------
  // Checks
  // --------------------
  // Sequence in progress keeps its instruction presented
  a_valid_has_inst: assert property (@(posedge split_clk) disable iff (!cpurst_b)
    (step_q != 2'd0) |-> in_valid);

  // Stalled micro-op holds until taken
  a_uop_stable: assert property (@(posedge split_clk) disable iff (!cpurst_b)
    (out_valid && !out_ready && !flush) |=> $stable(out_uop));

  a_step_bound: assert property (@(posedge split_clk) disable iff (!cpurst_b)
    (in_valid && (cls != CLS_NONE)) |-> (step_q < seq_len));

endmodule

/* hw/split_settings.svh */
// Field constants for the instruction splitter
// Only 32-bit encodings are matched, compressed forms never split
// Function codes are private to this splitter and only need to be distinct
`ifndef SPLIT_SETTINGS_SVH
`define SPLIT_SETTINGS_SVH

// Datapath widths
`define SPLIT_INST_W 32
`define SPLIT_IMM_W  64
`define SPLIT_FUNC_W 6

// Major opcodes, inst[6:0]
`define SPLIT_OPC_CUSTOM0 7'b0001011
`define SPLIT_OPC_AMO     7'b0101111
`define SPLIT_OPC_SYSTEM  7'b1110011

// Paired load/store match, {funct5, funct3}
`define SPLIT_LSD_LWD  8'b11100_100
`define SPLIT_LSD_LWUD 8'b11110_100
`define SPLIT_LSD_LDD  8'b11111_100
`define SPLIT_LSD_SWD  8'b11100_101
`define SPLIT_LSD_SDD  8'b11111_101

// Atomic funct5 values outside the funct5[1:0] == 0 group
`define SPLIT_AMO_LR   5'b00010
`define SPLIT_AMO_SC   5'b00011
`define SPLIT_AMO_SWAP 5'b00001

// sfence.vma funct7
`define SPLIT_SFENCE_F7 7'b0001001

// Micro-op function codes
`define SPLIT_FUNC_LW     6'd1
`define SPLIT_FUNC_LWU    6'd2
`define SPLIT_FUNC_LD     6'd3
`define SPLIT_FUNC_SW     6'd4
`define SPLIT_FUNC_SD     6'd5
`define SPLIT_FUNC_LR_W   6'd6
`define SPLIT_FUNC_LR_D   6'd7
`define SPLIT_FUNC_SC_W   6'd8
`define SPLIT_FUNC_SC_D   6'd9
`define SPLIT_FUNC_AMO_W  6'd10
`define SPLIT_FUNC_AMO_D  6'd11
`define SPLIT_FUNC_FENCE  6'd12
`define SPLIT_FUNC_SFENCE 6'd13
`define SPLIT_FUNC_SYNCI  6'd14

`endif

/* testbench/tb_inst_split.sv */
`timescale 1ns/1ps
// Directed testbench for the instruction splitter
// Inputs change on rising edges, outputs are sampled on falling edges
// Expected micro-ops are built field by field from the encodings
`include "split_settings.svh"

module tb_inst_split;
  import split_pkg::*;

  localparam int WAIT_LIMIT = 64;

  logic        split_clk;
  logic        cpurst_b;
  logic        in_valid;
  inst_t       in_inst;
  logic        custom_en;
  logic        flush;
  logic        out_ready;
  logic        in_ready;
  logic        out_valid;
  uop_t        out_uop;
  logic [31:0] lfsr_state;
  uop_t        got_q[$];
  uop_t        exp_q[$];
  int          valid_cycles;
  int          mismatch_cnt;
  int          timeout_cnt;

  inst_split_top u_inst_split_top (
    .split_clk (split_clk),
    .cpurst_b  (cpurst_b),
    .in_valid  (in_valid),
    .in_inst   (in_inst),
    .custom_en (custom_en),
    .flush     (flush),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_uop   (out_uop)
  );

  // --------------------
  // Clock and random source
  // --------------------
  always #2 split_clk = ~split_clk;

  // Galois LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b)
      lfsr_state = lfsr_state ^ 32'h80200003;
    return b;
  endfunction

  // --------------------
  // Encoders and expected micro-ops
  // --------------------
  function automatic inst_t enc_pair(logic [4:0] f5, logic [1:0] imm2, reg_idx_t rs2,
                                     reg_idx_t rs1, logic [2:0] f3, reg_idx_t rd);
    return {f5, imm2, rs2, rs1, f3, rd, `SPLIT_OPC_CUSTOM0};
  endfunction

  function automatic inst_t enc_amo(logic [4:0] f5, logic aq, logic rl, reg_idx_t rs2,
                                    reg_idx_t rs1, logic [2:0] f3, reg_idx_t rd);
    return {f5, aq, rl, rs2, rs1, f3, rd, `SPLIT_OPC_AMO};
  endfunction

  // All fields clear except unit, function, split and opcode
  function automatic uop_t base_uop(exec_unit_e eu, func_t f, logic split, inst_t op);
    uop_t u;
    u        = '0;
    u.eu     = eu;
    u.func   = f;
    u.split  = split;
    u.opcode = op;
    return u;
  endfunction

  // One half of a paired access, base always rs1
  function automatic uop_t pair_uop(inst_t op, func_t f, logic load, reg_idx_t base,
                                    reg_idx_t data, imm_t off, logic split);
    uop_t u;
    u          = base_uop(EU_LSU, f, split, op);
    u.src0_vld = 1'b1;
    u.src0_reg = base;
    u.imm_vld  = 1'b1;
    u.imm      = off;
    if (load)
    begin
      u.dst_vld = 1'b1;
      u.dst_reg = data;
    end
    else
    begin
      u.src2_vld = 1'b1;
      u.src2_reg = data;
    end
    return u;
  endfunction

  // Atomic body, rd always written
  function automatic uop_t amo_body(inst_t op, func_t f, reg_idx_t rs1, logic use_rs2,
                                    reg_idx_t rs2, reg_idx_t rd, logic split);
    uop_t u;
    u          = base_uop(EU_LSU, f, split, op);
    u.src0_vld = 1'b1;
    u.src0_reg = rs1;
    u.dst_vld  = 1'b1;
    u.dst_reg  = rd;
    if (use_rs2)
    begin
      u.src2_vld = 1'b1;
      u.src2_reg = rs2;
    end
    return u;
  endfunction

  // --------------------
  // Drive, collect and compare
  // --------------------
  task automatic present_inst(input inst_t inst, input logic cen, input logic rand_rdy);
    @(posedge split_clk);
    in_valid  <= 1'b1;
    in_inst   <= inst;
    custom_en <= cen;
    out_ready <= rand_rdy ? lfsr_bit() : 1'b1;
  endtask

  // Takes micro-ops until the instruction is consumed
  task automatic collect_uops(input logic rand_rdy);
    int   cycles;
    logic done;
    logic stalled;
    uop_t held;
    got_q.delete();
    valid_cycles = 0;
    cycles       = 0;
    done         = 1'b0;
    stalled      = 1'b0;
    held         = '0;
    while (!done && cycles < WAIT_LIMIT)
    begin
      @(negedge split_clk);
      // Stalled micro-op must hold
      if (stalled && out_valid && (out_uop !== held))
      begin
        mismatch_cnt++;
        $display("mismatch at %0t: out_uop changed while stalled", $time);
      end
      if (out_valid)
        valid_cycles++;
      if (out_valid && out_ready)
        got_q.push_back(out_uop);
      stalled = out_valid && !out_ready;
      held    = out_uop;
      done    = in_ready;
      @(posedge split_clk);
      if (!done && rand_rdy)
        out_ready <= lfsr_bit();
      cycles++;
    end
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    if (!done)
    begin
      timeout_cnt++;
      $display("timeout at %0t: instruction was never consumed", $time);
    end
  endtask

  task automatic compare_uop(input string name, input int idx, input uop_t got,
                             input uop_t exp);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s uop %0d got %h expected %h",
               $time, name, idx, got, exp);
    end
  endtask

  task automatic check_uops(input string name);
    if (got_q.size() != exp_q.size())
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s gave %0d uops, expected %0d",
               $time, name, got_q.size(), exp_q.size());
    end
    else
    begin
      foreach (exp_q[i])
      begin
        compare_uop(name, i, got_q[i], exp_q[i]);
      end
    end
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic test_lwd();
    inst_t inst;
    // imm2 of 1 scales to 8 for word pairs
    inst = enc_pair(5'b11100, 2'b01, 5'd7, 5'd3, 3'b100, 5'd5);
    exp_q.delete();
    exp_q.push_back(pair_uop(inst, `SPLIT_FUNC_LW, 1'b1, 5'd3, 5'd5, 64'd8, 1'b1));
    exp_q.push_back(pair_uop(inst, `SPLIT_FUNC_LW, 1'b1, 5'd3, 5'd7, 64'd12, 1'b0));
    present_inst(inst, 1'b1, 1'b0);
    collect_uops(1'b0);
    check_uops("lwd");
  endtask

  task automatic test_sdd();
    inst_t inst;
    // Double pairs scale imm2 by 16
    inst = enc_pair(5'b11111, 2'b11, 5'd10, 5'd2, 3'b101, 5'd9);
    exp_q.delete();
    exp_q.push_back(pair_uop(inst, `SPLIT_FUNC_SD, 1'b0, 5'd2, 5'd9, 64'd48, 1'b1));
    exp_q.push_back(pair_uop(inst, `SPLIT_FUNC_SD, 1'b0, 5'd2, 5'd10, 64'd56, 1'b0));
    present_inst(inst, 1'b1, 1'b1);
    collect_uops(1'b1);
    check_uops("sdd");
  endtask

  task automatic test_atomics();
    inst_t inst;
    uop_t  u;
    // amoadd.d aq rl, fenced on both sides
    inst = enc_amo(5'b00000, 1'b1, 1'b1, 5'd6, 5'd4, 3'b011, 5'd8);
    u = amo_body(inst, `SPLIT_FUNC_AMO_D, 5'd4, 1'b1, 5'd6, 5'd8, 1'b1);
    u.imm_vld = 1'b1;
    u.imm     = '0;
    exp_q.delete();
    exp_q.push_back(base_uop(EU_CP0, `SPLIT_FUNC_FENCE, 1'b1, inst));
    exp_q.push_back(u);
    exp_q.push_back(base_uop(EU_CP0, `SPLIT_FUNC_FENCE, 1'b0, inst));
    present_inst(inst, 1'b1, 1'b1);
    collect_uops(1'b1);
    check_uops("amoadd.d");
    // lr.w aq, trailing fence only
    inst = enc_amo(5'b00010, 1'b1, 1'b0, 5'd0, 5'd11, 3'b010, 5'd12);
    exp_q.delete();
    exp_q.push_back(amo_body(inst, `SPLIT_FUNC_LR_W, 5'd11, 1'b0, 5'd0, 5'd12, 1'b1));
    exp_q.push_back(base_uop(EU_CP0, `SPLIT_FUNC_FENCE, 1'b0, inst));
    present_inst(inst, 1'b1, 1'b1);
    collect_uops(1'b1);
    check_uops("lr.w");
    // sc.w alone
    inst = enc_amo(5'b00011, 1'b0, 1'b0, 5'd13, 5'd14, 3'b010, 5'd15);
    exp_q.delete();
    exp_q.push_back(amo_body(inst, `SPLIT_FUNC_SC_W, 5'd14, 1'b1, 5'd13, 5'd15, 1'b0));
    present_inst(inst, 1'b1, 1'b1);
    collect_uops(1'b1);
    check_uops("sc.w");
  endtask

  task automatic test_sfence();
    inst_t inst;
    uop_t  u;
    inst = {7'b0001001, 5'd18, 5'd17, 3'b000, 5'd0, 7'b1110011};
    exp_q.delete();
    u = base_uop(EU_CP0, `SPLIT_FUNC_SFENCE, 1'b1, inst);
    u.src0_vld = 1'b1;
    u.src0_reg = 5'd17;
    u.src1_vld = 1'b1;
    u.src1_reg = 5'd18;
    exp_q.push_back(u);
    u = base_uop(EU_CP0, `SPLIT_FUNC_SYNCI, 1'b0, inst);
    u.src0_vld = 1'b1;
    u.src0_reg = 5'd17;
    exp_q.push_back(u);
    present_inst(inst, 1'b1, 1'b1);
    collect_uops(1'b1);
    check_uops("sfence.vma");
  endtask

  // Consumed at once, nothing emitted
  task automatic check_passthrough(input string name, input inst_t inst, input logic cen);
    present_inst(inst, cen, 1'b0);
    collect_uops(1'b0);
    exp_q.delete();
    check_uops(name);
    if (valid_cycles != 0)
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s raised out_valid %0d times", $time, name, valid_cycles);
    end
  endtask

  task automatic test_flush();
    inst_t inst;
    uop_t  first_uop;
    inst = enc_pair(5'b11100, 2'b10, 5'd21, 5'd20, 3'b100, 5'd22);
    exp_q.delete();
    exp_q.push_back(pair_uop(inst, `SPLIT_FUNC_LW, 1'b1, 5'd20, 5'd22, 64'd16, 1'b1));
    exp_q.push_back(pair_uop(inst, `SPLIT_FUNC_LW, 1'b1, 5'd20, 5'd21, 64'd20, 1'b0));
    present_inst(inst, 1'b1, 1'b0);
    @(negedge split_clk);
    first_uop = out_uop;
    if (!out_valid)
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: flush test saw no first uop", $time);
    end
    compare_uop("flush first", 0, first_uop, exp_q[0]);
    // First uop taken here, flush lands on the second
    @(posedge split_clk);
    flush <= 1'b1;
    @(negedge split_clk);
    if (out_valid || in_ready)
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: handshake active during flush", $time);
    end
    @(posedge split_clk);
    flush <= 1'b0;
    collect_uops(1'b0);
    check_uops("flush restart");
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial
  begin
    split_clk    = 1'b0;
    cpurst_b     = 1'b0;
    in_valid     = 1'b0;
    in_inst      = '0;
    custom_en    = 1'b0;
    flush        = 1'b0;
    out_ready    = 1'b0;
    lfsr_state   = 32'h5772d252;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    repeat (2) @(posedge split_clk);
    cpurst_b <= 1'b1;
    test_lwd();
    test_sdd();
    test_atomics();
    test_sfence();
    check_passthrough("add", {7'b0, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011}, 1'b1);
    check_passthrough("lwd disabled", enc_pair(5'b11100, 2'b00, 5'd7, 5'd3, 3'b100, 5'd5),
                      1'b0);
    test_flush();
    repeat (2) @(posedge split_clk);
    $display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt + timeout_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule
